// ==== project.f ====
+incdir+.
lc4_pkg.sv
lc4_fwd_if.sv
lc4_pipe_reg.sv
lc4_fetch.sv
lc4_hazard_ctrl.sv
lc4_decode.sv
lc4_execute.sv
lc4_mem_wb.sv
lc4_core.sv
lc4_core_chk.sv
tb_lc4_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lc4_core -f project.f -o sim_tb_lc4_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/sim_tb_lc4_core 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== tb_lc4_core.sv ====
`include "lc4_defines.svh"

module tb_lc4_core import lc4_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NPROG          = 200;
    localparam int    RETIRE_TIMEOUT = 16;
    localparam word_t PROG_END       = `LC4_PC_RESET + 16'(NPROG);

    logic     gwe;
    logic     i_rst_n;
    word_t    i_cur_insn;
    word_t    i_cur_dmem_data;
    word_t    o_cur_pc, o_dmem_addr, o_dmem_towrite;
    logic     o_dmem_we;
    stall_e   o_test_stall;
    word_t    o_test_cur_pc, o_test_cur_insn, o_test_regfile_data;
    logic     o_test_regfile_we, o_test_nzp_we, o_test_dmem_we;
    reg_sel_t o_test_regfile_wsel;
    nzp_t     o_test_nzp_new_bits;
    word_t    o_test_dmem_addr, o_test_dmem_data;

    word_t imem [NPROG];
    word_t dmem [word_t];

    // ISA model state
    word_t mdl_pc;
    word_t mdl_regs [`LC4_NREGS];
    nzp_t  mdl_nzp;
    word_t mdl_mem [word_t];

    // what the model expects from the insn it just executed
    word_t    exp_pc, exp_insn, exp_rf_data, exp_addr, exp_mdata;
    reg_sel_t exp_wsel;
    nzp_t     exp_nzp;
    logic     exp_rf_we, exp_nzp_we, exp_dmem_we, exp_taken, exp_is_load;
    logic     cur_reads_rs, cur_reads_rt, cur_branch;
    reg_sel_t cur_rs, cur_rt;

    // data memory request of the insn that writeback shows now
    logic     wr_we;
    word_t    wr_addr, wr_data;

    lc4_core DUT (.*);

    initial begin
        gwe = 1'b0;
        forever begin
            #5 gwe = ~gwe;
        end
    end

    task automatic abort_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, want));
        end
    endtask

    task automatic check_nzp(input string name, input nzp_t got, input nzp_t want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, want));
        end
    endtask

    task automatic check_stall(input string name, input stall_e got, input stall_e want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, want));
        end
    endtask

    // data memory decodes only the low six address bits so loads and stores meet often
    function automatic word_t mem_index(word_t addr);
        return addr & 16'h003f;
    endfunction

    function automatic word_t fill_word(word_t idx);
        return (idx * 16'h9e37) ^ 16'h5a3c;
    endfunction

    function automatic word_t fetch_insn(word_t pc);
        word_t off;
        off = pc - `LC4_PC_RESET;
        if (off < 16'(NPROG)) begin
            return imem[off[7:0]];
        end
        // everything outside the program reads as NOP
        return 16'h0000;
    endfunction

    function automatic nzp_t sign_flags(word_t w);
        if (w[15]) begin
            return 3'b100;
        end
        if (w == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    function automatic word_t random_insn();
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        int         kind;
        rd   = 3'($urandom);
        rs   = 3'($urandom);
        rt   = 3'($urandom);
        kind = $urandom_range(0, 11);
        case (kind)
            0:       return {`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt};
            1:       return {`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt};
            2:       return {`LC4_OP_ARITH, rd, rs, 1'b1, 5'($urandom)};
            3:       return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt};
            4:       return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_OR, rt};
            5:       return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_XOR, rt};
            6:       return {`LC4_OP_CONST, rd, 9'($urandom)};
            7, 8:    return {`LC4_OP_LDR, rd, rs, 6'($urandom)};
            9:       return {`LC4_OP_STR, rd, rs, 6'($urandom)};
            // forward branches only, nzp of 000 gives a NOP
            default: return {`LC4_OP_BR, 3'($urandom), 9'($urandom_range(0, 5))};
        endcase
    endfunction

    // executes the insn at mdl_pc in program order
    task automatic model_step();
        word_t      insn;
        word_t      rs_v;
        word_t      rt_v;
        word_t      res;
        logic [3:0] op;
        insn = fetch_insn(mdl_pc);
        op   = insn[15:12];
        rs_v = mdl_regs[insn[8:6]];
        rt_v = mdl_regs[insn[2:0]];
        res  = 16'h0000;
        exp_pc      = mdl_pc;
        exp_insn    = insn;
        exp_wsel    = insn[11:9];
        exp_rf_we   = 1'b0;
        exp_nzp_we  = 1'b0;
        exp_dmem_we = 1'b0;
        exp_is_load = 1'b0;
        exp_taken   = 1'b0;
        exp_rf_data = 16'h0000;
        exp_nzp     = 3'b000;
        exp_addr    = 16'h0000;
        exp_mdata   = 16'h0000;
        cur_rs       = insn[8:6];
        cur_rt       = insn[2:0];
        cur_reads_rs = 1'b0;
        cur_reads_rt = 1'b0;
        cur_branch   = 1'b0;
        case (op)
            `LC4_OP_ARITH: begin
                cur_reads_rs = 1'b1;
                exp_rf_we    = 1'b1;
                if (insn[5]) begin
                    res = rs_v + {{11{insn[4]}}, insn[4:0]};
                end else begin
                    cur_reads_rt = 1'b1;
                    res = (insn[5:3] == `LC4_SUB_SUB) ? rs_v - rt_v : rs_v + rt_v;
                end
            end
            `LC4_OP_LOGIC: begin
                cur_reads_rs = 1'b1;
                cur_reads_rt = 1'b1;
                exp_rf_we    = 1'b1;
                if (insn[5:3] == `LC4_SUB_OR) begin
                    res = rs_v | rt_v;
                end else if (insn[5:3] == `LC4_SUB_XOR) begin
                    res = rs_v ^ rt_v;
                end else begin
                    res = rs_v & rt_v;
                end
            end
            `LC4_OP_CONST: begin
                exp_rf_we = 1'b1;
                res       = {{7{insn[8]}}, insn[8:0]};
            end
            `LC4_OP_LDR: begin
                cur_reads_rs = 1'b1;
                exp_rf_we    = 1'b1;
                exp_is_load  = 1'b1;
                exp_addr     = rs_v + {{10{insn[5]}}, insn[5:0]};
                exp_mdata    = mdl_mem[mem_index(exp_addr)];
                res          = exp_mdata;
            end
            `LC4_OP_STR: begin
                // the store data register is not a load-use dependency
                cur_reads_rs = 1'b1;
                exp_dmem_we  = 1'b1;
                exp_addr     = rs_v + {{10{insn[5]}}, insn[5:0]};
                exp_mdata    = mdl_regs[insn[11:9]];
                mdl_mem[mem_index(exp_addr)] = exp_mdata;
            end
            `LC4_OP_BR: begin
                cur_branch = |insn[11:9];
                exp_taken  = |(insn[11:9] & mdl_nzp);
            end
            default: res = 16'h0000;
        endcase
        if (exp_rf_we) begin
            exp_nzp_we  = 1'b1;
            exp_rf_data = res;
            exp_nzp     = sign_flags(res);
            mdl_regs[insn[11:9]] = res;
            mdl_nzp = exp_nzp;
        end
        mdl_pc = exp_taken ? mdl_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : mdl_pc + 16'd1;
    endtask

    // one clock, then answer the memory requests of the new cycle
    task automatic next_cycle();
        // the insn in memory now is the one writeback shows after this clock
        wr_we   = o_dmem_we;
        wr_addr = o_dmem_addr;
        wr_data = o_dmem_towrite;
        @(negedge gwe);
        if (o_dmem_we) begin
            dmem[mem_index(o_dmem_addr)] = o_dmem_towrite;
        end
        i_cur_insn      = fetch_insn(o_cur_pc);
        i_cur_dmem_data = dmem[mem_index(o_dmem_addr)];
    endtask

    task automatic check_enables_low();
        check_bit("o_test_regfile_we", o_test_regfile_we, 1'b0);
        check_bit("o_test_nzp_we", o_test_nzp_we, 1'b0);
        check_bit("o_test_dmem_we", o_test_dmem_we, 1'b0);
    endtask

    task automatic wait_retire(input stall_e code, output int seen);
        seen = 0;
        next_cycle();
        while (o_test_stall != STALL_NONE) begin
            check_stall("o_test_stall", o_test_stall, code);
            check_enables_low();
            check_bit("o_dmem_we", wr_we, 1'b0);
            seen++;
            if (seen > RETIRE_TIMEOUT) begin
                abort_run($sformatf("no instruction retired within %0d cycles, model pc %h",
                                    RETIRE_TIMEOUT, exp_pc));
            end
            next_cycle();
        end
    endtask

    task automatic compare_retired();
        check_word("o_test_cur_pc", o_test_cur_pc, exp_pc);
        check_word("o_test_cur_insn", o_test_cur_insn, exp_insn);
        check_bit("o_test_regfile_we", o_test_regfile_we, exp_rf_we);
        if (exp_rf_we) begin
            check_sel("o_test_regfile_wsel", o_test_regfile_wsel, exp_wsel);
            check_word("o_test_regfile_data", o_test_regfile_data, exp_rf_data);
        end
        check_bit("o_test_nzp_we", o_test_nzp_we, exp_nzp_we);
        if (exp_nzp_we) begin
            check_nzp("o_test_nzp_new_bits", o_test_nzp_new_bits, exp_nzp);
        end
        check_bit("o_test_dmem_we", o_test_dmem_we, exp_dmem_we);
        check_word("o_test_dmem_addr", o_test_dmem_addr, exp_addr);
        check_word("o_test_dmem_data", o_test_dmem_data, exp_mdata);
        check_bit("o_dmem_we", wr_we, exp_dmem_we);
        check_word("o_dmem_addr", wr_addr, exp_addr);
        if (exp_dmem_we) begin
            check_word("o_dmem_towrite", wr_data, exp_mdata);
        end
    endtask

    initial begin
        int       seen;
        int       want;
        int       n_retired;
        stall_e   code;
        logic     prev_taken;
        logic     prev_load;
        reg_sel_t prev_wsel;
        i_rst_n         = 1'b0;
        i_cur_insn      = 16'h0000;
        i_cur_dmem_data = 16'h0000;
        void'($urandom(22431));
        for (int i = 0; i < NPROG; i++) begin
            imem[i[7:0]] = random_insn();
        end
        for (int a = 0; a < 64; a++) begin
            dmem[16'(a)]    = fill_word(16'(a));
            mdl_mem[16'(a)] = fill_word(16'(a));
        end
        mdl_regs = '{default: 16'h0000};
        mdl_nzp  = 3'b000;
        mdl_pc   = `LC4_PC_RESET;

        repeat (5) begin
            next_cycle();
            check_word("o_cur_pc", o_cur_pc, `LC4_PC_RESET);
            check_stall("o_test_stall", o_test_stall, STALL_BRANCH);
            check_bit("o_dmem_we", o_dmem_we, 1'b0);
            check_enables_low();
        end
        i_rst_n = 1'b1;

        prev_taken = 1'b0;
        prev_load  = 1'b0;
        prev_wsel  = 3'd0;
        n_retired  = 0;
        while (mdl_pc < PROG_END) begin
            model_step();
            // bubbles ahead of this insn follow from the one retired before it
            code = STALL_NONE;
            want = 0;
            if (n_retired == 0 || prev_taken) begin
                code = STALL_BRANCH;
                want = 2;
            end else if (prev_load && (cur_branch || (cur_reads_rs && cur_rs == prev_wsel) ||
                                       (cur_reads_rt && cur_rt == prev_wsel))) begin
                code = STALL_LOAD;
                want = 1;
            end
            wait_retire(code, seen);
            if (n_retired != 0 && seen != want) begin
                abort_run($sformatf("Mismatch at %0t: bubbles ahead of pc %h got %0d expected %0d",
                                    $time, exp_pc, seen, want));
            end
            compare_retired();
            prev_taken = exp_taken;
            prev_load  = exp_is_load;
            prev_wsel  = exp_wsel;
            n_retired++;
        end

        for (int a = 0; a < 64; a++) begin
            check_word($sformatf("dmem[%0d]", a), dmem[16'(a)], mdl_mem[16'(a)]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== lc4_core_chk.sv ====
`include "lc4_defines.svh"

module lc4_core_chk import lc4_pkg::*; (
    input logic       gwe,
    input logic       i_rst_n,
    input logic [1:0] i_stall,
    input word_t      i_insn,
    input logic       i_regfile_we,
    input logic       i_nzp_we,
    input logic       i_dmem_we
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] op;
    logic       writes_reg;

    assign op = i_insn[15:12];
    // only ALU, CONST and load insns reach the register file
    assign writes_reg = (op == `LC4_OP_ARITH) || (op == `LC4_OP_LOGIC) ||
                        (op == `LC4_OP_LDR) || (op == `LC4_OP_CONST);

    // code 1 was the second pipe's and cannot appear in a single pipe
    a_no_code_one: assert property (@(posedge gwe) disable iff (!i_rst_n) i_stall != 2'd1)
        else $error("stall code 1 on the writeback test port");

    a_bubble_quiet: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_stall != 2'd0) |-> !(i_regfile_we || i_nzp_we || i_dmem_we))
        else $error("write enable raised in a bubble cycle");

    a_we_opcode: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_regfile_we |-> writes_reg)
        else $error("register write from an opcode that writes no register");

    a_store_opcode: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_dmem_we |-> (op == `LC4_OP_STR))
        else $error("data memory write from a non-store opcode");

endmodule

bind lc4_core lc4_core_chk u_chk (
    .gwe(gwe),
    .i_rst_n(i_rst_n),
    .i_stall(o_test_stall),
    .i_insn(o_test_cur_insn),
    .i_regfile_we(o_test_regfile_we),
    .i_nzp_we(o_test_nzp_we),
    .i_dmem_we(o_test_dmem_we)
);

// ==== lc4_core.sv ====
module lc4_core import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  word_t    i_cur_insn,
    input  word_t    i_cur_dmem_data,
    output word_t    o_cur_pc,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_towrite,
    output stall_e   o_test_stall,
    output word_t    o_test_cur_pc,
    output word_t    o_test_cur_insn,
    output logic     o_test_regfile_we,
    output reg_sel_t o_test_regfile_wsel,
    output word_t    o_test_regfile_data,
    output logic     o_test_nzp_we,
    output nzp_t     o_test_nzp_new_bits,
    output logic     o_test_dmem_we,
    output word_t    o_test_dmem_addr,
    output word_t    o_test_dmem_data
);

    fd_t    fd_d, fd_q;
    dx_t    dx_d, dx_q;
    xm_t    xm_d, xm_q;
    mw_t    mw_d, mw_q;
    stall_e fd_stall, dx_stall, xm_stall;
    ctrl_t  d_ctrl;
    logic   hold_front, flush_fd, bubble_dx, branch_taken, ld_nzp_we;
    stall_e bubble_code;
    word_t  branch_target;
    nzp_t   ld_nzp;

    lc4_fwd_if fwd ();

    lc4_fetch u_fetch (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(hold_front),
        .i_redirect(branch_taken), .i_target(branch_target), .o_pc(o_cur_pc)
    );

    assign fd_d.pc   = o_cur_pc;
    assign fd_d.insn = i_cur_insn;

    lc4_hazard_ctrl u_hazard (
        .i_d_ctrl(d_ctrl), .i_x_ctrl(dx_q.ctrl), .i_branch_taken(branch_taken),
        .o_hold_front(hold_front), .o_flush_fd(flush_fd),
        .o_bubble_dx(bubble_dx), .o_bubble_code(bubble_code)
    );

    lc4_pipe_reg #(.T(fd_t)) u_fd_reg (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(hold_front), .i_bubble(flush_fd),
        .i_bubble_code(STALL_BRANCH), .i_data(fd_d), .i_stall(STALL_NONE),
        .o_data(fd_q), .o_stall(fd_stall)
    );

    lc4_decode u_decode (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_fd(fd_q), .fwd(fwd),
        .o_dx(dx_d), .o_ctrl(d_ctrl)
    );

    lc4_pipe_reg #(.T(dx_t)) u_dx_reg (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(bubble_dx),
        .i_bubble_code(bubble_code), .i_data(dx_d), .i_stall(fd_stall),
        .o_data(dx_q), .o_stall(dx_stall)
    );

    lc4_execute u_execute (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_dx(dx_q), .i_ld_nzp_we(ld_nzp_we),
        .i_ld_nzp(ld_nzp), .fwd(fwd), .o_xm(xm_d),
        .o_branch_taken(branch_taken), .o_branch_target(branch_target)
    );

    lc4_pipe_reg #(.T(xm_t)) u_xm_reg (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(1'b0),
        .i_bubble_code(STALL_NONE), .i_data(xm_d), .i_stall(dx_stall),
        .o_data(xm_q), .o_stall(xm_stall)
    );

    lc4_mem_wb u_mem_wb (
        .i_xm(xm_q), .i_mw(mw_q), .i_dmem_rdata(i_cur_dmem_data),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
        .o_dmem_towrite(o_dmem_towrite), .o_mw_next(mw_d),
        .o_ld_nzp_we(ld_nzp_we), .o_ld_nzp(ld_nzp), .fwd(fwd)
    );

    lc4_pipe_reg #(.T(mw_t)) u_mw_reg (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(1'b0),
        .i_bubble_code(STALL_NONE), .i_data(mw_d), .i_stall(xm_stall),
        .o_data(mw_q), .o_stall(o_test_stall)
    );

    // test ports all report the writeback stage
    assign o_test_cur_pc       = mw_q.pc;
    assign o_test_cur_insn     = mw_q.insn;
    assign o_test_regfile_we   = fwd.w_we;
    assign o_test_regfile_wsel = fwd.w_wsel;
    assign o_test_regfile_data = fwd.w_value;
    assign o_test_nzp_we       = mw_q.ctrl.nzp_we;
    assign o_test_nzp_new_bits = mw_q.nzp;
    assign o_test_dmem_we      = mw_q.ctrl.is_store;
    assign o_test_dmem_addr    = (mw_q.ctrl.is_load || mw_q.ctrl.is_store) ? mw_q.result : '0;
    assign o_test_dmem_data    = mw_q.ctrl.is_load  ? mw_q.load_val  :
                                 mw_q.ctrl.is_store ? mw_q.store_val : '0;

endmodule

// ==== lc4_mem_wb.sv ====
module lc4_mem_wb import lc4_pkg::*; (
    input  xm_t       i_xm,
    input  mw_t       i_mw,
    input  word_t     i_dmem_rdata,
    output word_t     o_dmem_addr,
    output logic      o_dmem_we,
    output word_t     o_dmem_towrite,
    output mw_t       o_mw_next,
    output logic      o_ld_nzp_we,
    output nzp_t      o_ld_nzp,
    lc4_fwd_if.src    fwd
);

    word_t wb_value;
    word_t store_val;
    logic  mem_access;

    // writeback value, load data or ALU result
    assign wb_value = i_mw.ctrl.is_load ? i_mw.load_val : i_mw.result;

    // WM bypass of store data
    assign store_val = (i_mw.ctrl.regfile_we && i_mw.ctrl.wsel == i_xm.ctrl.r2sel)
                       ? wb_value : i_xm.store_val;

    assign mem_access     = i_xm.ctrl.is_load || i_xm.ctrl.is_store;
    assign o_dmem_addr    = mem_access ? i_xm.result : '0;
    assign o_dmem_we      = i_xm.ctrl.is_store;
    assign o_dmem_towrite = i_xm.ctrl.is_store ? store_val : '0;

    assign o_ld_nzp_we = i_xm.ctrl.is_load;
    assign o_ld_nzp    = nzp_of(i_dmem_rdata);

    assign o_mw_next.pc        = i_xm.pc;
    assign o_mw_next.insn      = i_xm.insn;
    assign o_mw_next.ctrl      = i_xm.ctrl;
    assign o_mw_next.result    = i_xm.result;
    assign o_mw_next.store_val = i_xm.ctrl.is_store ? store_val : '0;
    assign o_mw_next.load_val  = i_xm.ctrl.is_load ? i_dmem_rdata : '0;
    assign o_mw_next.nzp       = i_xm.ctrl.is_load ? o_ld_nzp : i_xm.nzp;

    // a load in memory has no value yet, the stall covers its consumers
    assign fwd.m_we    = i_xm.ctrl.regfile_we && !i_xm.ctrl.is_load;
    assign fwd.m_wsel  = i_xm.ctrl.wsel;
    assign fwd.m_value = i_xm.result;

    assign fwd.w_we    = i_mw.ctrl.regfile_we;
    assign fwd.w_wsel  = i_mw.ctrl.wsel;
    assign fwd.w_value = wb_value;

endmodule

// ==== lc4_execute.sv ====
`include "lc4_defines.svh"

module lc4_execute import lc4_pkg::*; (
    input  logic          gwe,
    input  logic          i_rst_n,
    input  dx_t           i_dx,
    input  logic          i_ld_nzp_we,
    input  nzp_t          i_ld_nzp,
    lc4_fwd_if.sink       fwd,
    output xm_t           o_xm,
    output logic          o_branch_taken,
    output word_t         o_branch_target
);

    ctrl_t ctrl;
    word_t insn;
    word_t rs;
    word_t rt;
    word_t result;
    nzp_t  nzp_q;
    logic  alu_nzp_we;

    assign ctrl = i_dx.ctrl;
    assign insn = i_dx.insn;

    // MX first, then WX, then the value read in decode
    always_comb begin
        if (fwd.m_we && fwd.m_wsel == ctrl.r1sel) begin
            rs = fwd.m_value;
        end else if (fwd.w_we && fwd.w_wsel == ctrl.r1sel) begin
            rs = fwd.w_value;
        end else begin
            rs = i_dx.rs_val;
        end
        if (fwd.m_we && fwd.m_wsel == ctrl.r2sel) begin
            rt = fwd.m_value;
        end else if (fwd.w_we && fwd.w_wsel == ctrl.r2sel) begin
            rt = fwd.w_value;
        end else begin
            rt = i_dx.rt_val;
        end
    end

    always_comb begin
        result = '0;
        case (insn[15:12])
            `LC4_OP_ARITH: begin
                if (insn[5]) begin
                    result = rs + {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == `LC4_SUB_SUB) begin
                    result = rs - rt;
                end else begin
                    result = rs + rt;
                end
            end
            `LC4_OP_LOGIC: begin
                case (insn[5:3])
                    `LC4_SUB_OR:  result = rs | rt;
                    `LC4_SUB_XOR: result = rs ^ rt;
                    default:      result = rs & rt;
                endcase
            end
            `LC4_OP_LDR,
            `LC4_OP_STR:   result = rs + {{10{insn[5]}}, insn[5:0]};
            `LC4_OP_CONST: result = {{7{insn[8]}}, insn[8:0]};
            default:       result = '0;
        endcase
    end

    // loads set nzp later, from memory data
    assign alu_nzp_we = ctrl.nzp_we && !ctrl.is_load;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= '0;
        end else if (alu_nzp_we) begin
            nzp_q <= nzp_of(result);
        end else if (i_ld_nzp_we) begin
            nzp_q <= i_ld_nzp;
        end
    end

    assign o_branch_taken  = ctrl.is_branch && |(insn[11:9] & nzp_q);
    assign o_branch_target = i_dx.pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};

    assign o_xm.pc        = i_dx.pc;
    assign o_xm.insn      = insn;
    assign o_xm.ctrl      = ctrl;
    assign o_xm.result    = result;
    assign o_xm.store_val = rt;
    assign o_xm.nzp       = nzp_of(result);

endmodule

// ==== lc4_decode.sv ====
`include "lc4_defines.svh"

module lc4_decode import lc4_pkg::*; (
    input  logic          gwe,
    input  logic          i_rst_n,
    input  fd_t           i_fd,
    lc4_fwd_if.sink       fwd,
    output dx_t           o_dx,
    output ctrl_t         o_ctrl
);

    word_t    regs [`LC4_NREGS];
    word_t    insn;
    logic [2:0] sub;
    ctrl_t    ctrl;

    assign insn = i_fd.insn;
    assign sub  = insn[5:3];

    always_comb begin
        ctrl = '0;
        case (insn[15:12])
            // nzp == 000 is the NOP and never branches
            `LC4_OP_BR: ctrl.is_branch = |insn[11:9];
            `LC4_OP_ARITH: begin
                if (insn[5] || sub == `LC4_SUB_ADD || sub == `LC4_SUB_SUB) begin
                    ctrl.r1sel      = insn[8:6];
                    ctrl.r1re       = 1'b1;
                    ctrl.r2sel      = insn[2:0];
                    ctrl.r2re       = !insn[5];
                    ctrl.wsel       = insn[11:9];
                    ctrl.regfile_we = 1'b1;
                    ctrl.nzp_we     = 1'b1;
                end
            end
            `LC4_OP_LOGIC: begin
                if (sub == `LC4_SUB_AND || sub == `LC4_SUB_OR || sub == `LC4_SUB_XOR) begin
                    ctrl.r1sel      = insn[8:6];
                    ctrl.r1re       = 1'b1;
                    ctrl.r2sel      = insn[2:0];
                    ctrl.r2re       = 1'b1;
                    ctrl.wsel       = insn[11:9];
                    ctrl.regfile_we = 1'b1;
                    ctrl.nzp_we     = 1'b1;
                end
            end
            `LC4_OP_LDR: begin
                ctrl.r1sel      = insn[8:6];
                ctrl.r1re       = 1'b1;
                ctrl.wsel       = insn[11:9];
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
                ctrl.is_load    = 1'b1;
            end
            `LC4_OP_STR: begin
                // rt holds the data to store
                ctrl.r1sel    = insn[8:6];
                ctrl.r1re     = 1'b1;
                ctrl.r2sel    = insn[11:9];
                ctrl.r2re     = 1'b1;
                ctrl.is_store = 1'b1;
            end
            `LC4_OP_CONST: begin
                ctrl.wsel       = insn[11:9];
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
        end else if (fwd.w_we) begin
            regs[fwd.w_wsel] <= fwd.w_value;
        end
    end

    // WD bypass of a same-cycle writeback
    assign o_dx.rs_val = (fwd.w_we && fwd.w_wsel == ctrl.r1sel) ? fwd.w_value
                                                                : regs[ctrl.r1sel];
    assign o_dx.rt_val = (fwd.w_we && fwd.w_wsel == ctrl.r2sel) ? fwd.w_value
                                                                : regs[ctrl.r2sel];
    assign o_dx.pc     = i_fd.pc;
    assign o_dx.insn   = insn;
    assign o_dx.ctrl   = ctrl;
    assign o_ctrl      = ctrl;

endmodule

// ==== lc4_hazard_ctrl.sv ====
module lc4_hazard_ctrl import lc4_pkg::*; (
    input  ctrl_t  i_d_ctrl,
    input  ctrl_t  i_x_ctrl,
    input  logic   i_branch_taken,
    output logic   o_hold_front,
    output logic   o_flush_fd,
    output logic   o_bubble_dx,
    output stall_e o_bubble_code
);

    logic rs_dep;
    logic rt_dep;
    logic load_use;

    // store data (rt) is excluded, it is fixed later by the WM bypass
    assign rs_dep = i_d_ctrl.r1re && (i_d_ctrl.r1sel == i_x_ctrl.wsel);
    assign rt_dep = i_d_ctrl.r2re && !i_d_ctrl.is_store &&
                    (i_d_ctrl.r2sel == i_x_ctrl.wsel);

    // a branch needs the load's nzp, which is only known after memory
    assign load_use = i_x_ctrl.is_load && (rs_dep || rt_dep || i_d_ctrl.is_branch);

    always_comb begin
        o_hold_front  = 1'b0;
        o_flush_fd    = 1'b0;
        o_bubble_dx   = 1'b0;
        o_bubble_code = STALL_NONE;
        if (i_branch_taken) begin
            // squash the two younger insns in fetch and decode
            o_flush_fd    = 1'b1;
            o_bubble_dx   = 1'b1;
            o_bubble_code = STALL_BRANCH;
        end else if (load_use) begin
            o_hold_front  = 1'b1;
            o_bubble_dx   = 1'b1;
            o_bubble_code = STALL_LOAD;
        end
    end

endmodule

// ==== lc4_fetch.sv ====
`include "lc4_defines.svh"

module lc4_fetch import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_rst_n,
    input  logic  i_hold,
    input  logic  i_redirect,
    input  word_t i_target,
    output word_t o_pc
);

    word_t pc_next;

    // redirect beats hold, a taken branch cancels the stalled insn
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_hold) begin
            pc_next = o_pc;
        end else begin
            pc_next = o_pc + 16'd1;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `LC4_PC_RESET;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

// ==== lc4_pipe_reg.sv ====
module lc4_pipe_reg import lc4_pkg::*; #(
    parameter type T = fd_t
) (
    input  logic   gwe,
    input  logic   i_rst_n,
    input  logic   i_hold,
    input  logic   i_bubble,
    input  stall_e i_bubble_code,
    input  T       i_data,
    input  stall_e i_stall,
    output T       o_data,
    output stall_e o_stall
);

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data  <= '0;
            o_stall <= STALL_BRANCH;
        end else if (!i_hold) begin
            // a bubble is an all-zero payload, which decodes as NOP
            if (i_bubble) begin
                o_data  <= '0;
                o_stall <= i_bubble_code;
            end else begin
                o_data  <= i_data;
                o_stall <= i_stall;
            end
        end
    end

endmodule

// ==== lc4_fwd_if.sv ====
// destination values of the memory and writeback stages,
// consumed by the bypass muxes in decode and execute
interface lc4_fwd_if import lc4_pkg::*; ();

    logic     m_we;
    reg_sel_t m_wsel;
    word_t    m_value;

    logic     w_we;
    reg_sel_t w_wsel;
    word_t    w_value;

    modport src (
        output m_we, m_wsel, m_value,
        output w_we, w_wsel, w_value
    );

    modport sink (
        input m_we, m_wsel, m_value,
        input w_we, w_wsel, w_value
    );

endinterface

// ==== lc4_pkg.sv ====
`include "lc4_defines.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0]       word_t;
    typedef logic [$clog2(`LC4_NREGS)-1:0] reg_sel_t;
    typedef logic [2:0]                   nzp_t;

    // stall code reported with every writeback cycle
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

    // decoded control, travels with the instruction to writeback
    typedef struct packed {
        reg_sel_t r1sel;
        reg_sel_t r2sel;
        reg_sel_t wsel;
        logic     r1re;
        logic     r2re;
        logic     regfile_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t insn;
    } fd_t;

    typedef struct packed {
        word_t pc;
        word_t insn;
        ctrl_t ctrl;
        word_t rs_val;
        word_t rt_val;
    } dx_t;

    typedef struct packed {
        word_t pc;
        word_t insn;
        ctrl_t ctrl;
        word_t result;
        word_t store_val;
        nzp_t  nzp;
    } xm_t;

    typedef struct packed {
        word_t pc;
        word_t insn;
        ctrl_t ctrl;
        word_t result;
        word_t store_val;
        word_t load_val;
        nzp_t  nzp;
    } mw_t;

    // sign of a word as one-hot n/z/p
    function automatic nzp_t nzp_of(word_t w);
        if ($signed(w) < 0) begin
            return 3'b100;
        end else if (w == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

endpackage

// ==== lc4_defines.svh ====
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// first fetch address after reset
`define LC4_PC_RESET 16'h8200

`define LC4_WORD_W   16
`define LC4_NREGS    8

// major opcodes, insn[15:12]
`define LC4_OP_BR    4'b0000
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_LDR   4'b0110
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

// sub-opcodes, insn[5:3]
`define LC4_SUB_ADD  3'b000
`define LC4_SUB_SUB  3'b010
`define LC4_SUB_AND  3'b000
`define LC4_SUB_OR   3'b010
`define LC4_SUB_XOR  3'b011

`endif
